/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_gmii_rx
	./obj_dir/Vtb_gmii_rx | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

/* hw/gmii_rx_pkg.sv */
// gmii receive package: word, timestamp and port types, fsm enums, reader and merger beats

`default_nettype none

`include "gmii_rx_consts.svh"

package gmii_rx_pkg;

        // mark bit sits above the byte
        typedef logic [`GMII_RX_WORD_W-1:0] frame_word_t;
        typedef logic [`GMII_RX_TS_W-1:0]   rx_ts_t;
        typedef logic [0:0]                 port_id_t;

        typedef enum logic [2:0] {
                RD_IDLE    = 3'd0,
                RD_HEAD    = 3'd1,
                RD_TRAN    = 3'd2,
                RD_DISCARD = 3'd3,
                RD_UFLOW   = 3'd4
        } rd_state_e;

        typedef enum logic {
                MG_IDLE = 1'b0,
                MG_HOLD = 1'b1
        } mg_state_e;

        // one reader output word, ts only set on the head
        typedef struct packed {
                logic        wr;
                frame_word_t word;
                rx_ts_t      ts;
                logic        tail;
                logic        underflow;
        } rx_beat_s;

        typedef struct packed {
                port_id_t port;
                rx_beat_s beat;
        } mrg_beat_s;

endpackage

`default_nettype wire

/* hw/gmii_rx_reader.sv */
// frame reader: start delay, head check, receive timestamp, tail detect, underflow recovery

`timescale 1ns/1ps
`default_nettype none

`include "gmii_rx_consts.svh"

module gmii_rx_reader
        import gmii_rx_pkg::*;
(
        input  wire logic        i_clk,
        input  wire logic        i_rst_n,
        input  wire frame_word_t i_word,
        input  wire logic        i_empty,
        input  wire rx_ts_t      i_timer,
        input  wire logic        i_grant,
        output logic             o_rd,
        output logic             o_req,
        output rx_beat_s         o_beat
);

        localparam int DLY = `GMII_RX_START_DELAY;
        localparam int CW  = $clog2(DLY + 1);
        localparam frame_word_t UFLOW_WORD = {1'b1, {(`GMII_RX_WORD_W - 1){1'b0}}};

        rd_state_e     state;
        logic [CW-1:0] dly_cnt;
        // fifo output holds a freshly read word
        logic          word_vld;
        logic          mark;

        assign mark  = i_word[`GMII_RX_WORD_W-1];
        assign o_req = (state == RD_IDLE) && !i_empty;

        ////////////////////////////////////////////////////////////////////////////
        // read strobe, never issued against an empty fifo
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                case (state)
                        // head read goes out in the last delay cycle
                        RD_IDLE: o_rd = i_grant && !i_empty && (dly_cnt == CW'(DLY - 1));
                        RD_HEAD: o_rd = !i_empty;
                        // stop once the visible word carries a mark
                        RD_TRAN, RD_DISCARD, RD_UFLOW: o_rd = !i_empty && !(word_vld && mark);
                        default: o_rd = 1'b0;
                endcase
        end

        ////////////////////////////////////////////////////////////////////////////
        // fsm and output beat
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        state    <= RD_IDLE;
                        dly_cnt  <= '0;
                        word_vld <= 1'b0;
                        o_beat   <= '0;
                end else begin
                        word_vld <= o_rd;
                        o_beat   <= '0;
                        case (state)
                                RD_IDLE: begin
                                        if (i_grant && !i_empty) begin
                                                if (dly_cnt == CW'(DLY - 1)) begin
                                                        dly_cnt <= '0;
                                                        state   <= RD_HEAD;
                                                end else begin
                                                        dly_cnt <= dly_cnt + 1'b1;
                                                end
                                        end else begin
                                                dly_cnt <= '0;
                                        end
                                end
                                RD_HEAD: begin
                                        if (word_vld && mark) begin
                                                o_beat.wr   <= 1'b1;
                                                o_beat.word <= i_word;
                                                o_beat.ts   <= i_timer;
                                                state       <= RD_TRAN;
                                        end else begin
                                                // body word without a head, drop to its tail
                                                state <= RD_DISCARD;
                                        end
                                end
                                RD_TRAN: begin
                                        o_beat.wr <= 1'b1;
                                        if (!word_vld) begin
                                                // fifo ran dry mid-frame, close with a forced mark
                                                o_beat.word      <= UFLOW_WORD;
                                                o_beat.underflow <= 1'b1;
                                                state            <= RD_UFLOW;
                                        end else begin
                                                o_beat.word <= i_word;
                                                if (mark) begin
                                                        o_beat.tail <= 1'b1;
                                                        state       <= RD_IDLE;
                                                end
                                        end
                                end
                                RD_DISCARD, RD_UFLOW: begin
                                        if (word_vld && mark) begin
                                                state <= RD_IDLE;
                                        end
                                end
                                default: state <= RD_IDLE;
                        endcase
                end
        end

endmodule

`default_nettype wire

/* hw/gmii_rx_top.sv */
// two-port gmii receive front end: writer, fifo and reader per port, then the frame merger

`timescale 1ns/1ps
`default_nettype none

module gmii_rx_top
        import gmii_rx_pkg::*;
(
        input  wire logic       i_clk,
        input  wire logic       i_rst_n,
        input  wire logic [7:0] i_rxd0,
        input  wire logic       i_rx_dv0,
        input  wire logic [7:0] i_rxd1,
        input  wire logic       i_rx_dv1,
        input  wire rx_ts_t     i_timer,
        output mrg_beat_s       o_out
);

        ////////////////////////////////////////////////////////////////////////////
        // port 0
        ////////////////////////////////////////////////////////////////////////////

        logic        wr0, empty0, rd0, req0, grant0;
        frame_word_t wword0, rword0;
        rx_beat_s    beat0;

        gmii_rx_writer u_writer0 (.i_clk, .i_rst_n, .i_rxd(i_rxd0), .i_rx_dv(i_rx_dv0),
                .o_wr(wr0), .o_word(wword0));
        rx_fifo u_fifo0 (.i_clk, .i_rst_n, .i_wr(wr0), .i_word(wword0), .i_rd(rd0),
                .o_word(rword0), .o_empty(empty0));
        gmii_rx_reader u_reader0 (.i_clk, .i_rst_n, .i_word(rword0), .i_empty(empty0),
                .i_timer, .i_grant(grant0), .o_rd(rd0), .o_req(req0), .o_beat(beat0));

        ////////////////////////////////////////////////////////////////////////////
        // port 1
        ////////////////////////////////////////////////////////////////////////////

        logic        wr1, empty1, rd1, req1, grant1;
        frame_word_t wword1, rword1;
        rx_beat_s    beat1;

        gmii_rx_writer u_writer1 (.i_clk, .i_rst_n, .i_rxd(i_rxd1), .i_rx_dv(i_rx_dv1),
                .o_wr(wr1), .o_word(wword1));
        rx_fifo u_fifo1 (.i_clk, .i_rst_n, .i_wr(wr1), .i_word(wword1), .i_rd(rd1),
                .o_word(rword1), .o_empty(empty1));
        gmii_rx_reader u_reader1 (.i_clk, .i_rst_n, .i_word(rword1), .i_empty(empty1),
                .i_timer, .i_grant(grant1), .o_rd(rd1), .o_req(req1), .o_beat(beat1));

        // frame-level arbitration of both channels
        rx_frame_merge u_merge (.i_clk, .i_rst_n, .i_req0(req0), .i_req1(req1),
                .i_beat0(beat0), .i_beat1(beat1), .o_grant0(grant0), .o_grant1(grant1),
                .o_out);

endmodule

`default_nettype wire

/* hw/gmii_rx_writer.sv */
// gmii frame writer: receive byte stream to marked 9-bit fifo words via a one-byte hold

`timescale 1ns/1ps
`default_nettype none

`include "gmii_rx_consts.svh"

module gmii_rx_writer
        import gmii_rx_pkg::*;
(
        input  wire logic       i_clk,
        input  wire logic       i_rst_n,
        input  wire logic [7:0] i_rxd,
        input  wire logic       i_rx_dv,
        output logic            o_wr,
        output frame_word_t     o_word
);

        localparam int MIN_LEN = `GMII_RX_MIN_LEN;
        localparam int CW      = $clog2(MIN_LEN + 1);

        // byte seen last cycle, emitted one cycle late
        logic [7:0]    hold_byte;
        // bytes in the current burst, saturates at the minimum length
        logic [CW-1:0] burst_cnt;
        logic          head;
        logic          tail;

        always_ff @(posedge i_clk) begin
                if (i_rx_dv) begin
                        hold_byte <= i_rxd;
                end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        burst_cnt <= '0;
                end else if (!i_rx_dv) begin
                        burst_cnt <= '0;
                end else if (burst_cnt != CW'(MIN_LEN)) begin
                        burst_cnt <= burst_cnt + 1'b1;
                end
        end

        // first byte of the burst is the one held with count one
        assign head = (burst_cnt == CW'(1));
        // dv has dropped, so the held byte is the last one
        assign tail = !i_rx_dv;

        // a short burst only ever risks its held first byte
        assign o_wr   = (burst_cnt != '0) && (i_rx_dv || burst_cnt == CW'(MIN_LEN));
        assign o_word = {head | tail, hold_byte};

endmodule

`default_nettype wire

/* hw/rx_fifo.sv */
// frame word fifo: circular buffer, wrap-bit pointers, registered read data, empty flag

`timescale 1ns/1ps
`default_nettype none

`include "gmii_rx_consts.svh"

module rx_fifo
        import gmii_rx_pkg::*;
#(
        parameter int DEPTH = `GMII_RX_FIFO_DEPTH
) (
        input  wire logic        i_clk,
        input  wire logic        i_rst_n,
        input  wire logic        i_wr,
        input  wire frame_word_t i_word,
        input  wire logic        i_rd,
        output frame_word_t      o_word,
        output logic             o_empty
);

        localparam int AW = $clog2(DEPTH);

        frame_word_t mem [DEPTH];
        // extra top bit tells a full wrap from empty
        logic [AW:0] wptr;
        logic [AW:0] rptr;

        assign o_empty = (wptr == rptr);

        always_ff @(posedge i_clk) begin
                if (i_wr) begin
                        mem[wptr[AW-1:0]] <= i_word;
                end
        end

        // read data holds until the next accepted read
        always_ff @(posedge i_clk) begin
                if (i_rd && !o_empty) begin
                        o_word <= mem[rptr[AW-1:0]];
                end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        wptr <= '0;
                        rptr <= '0;
                end else begin
                        if (i_wr) begin
                                wptr <= wptr + 1'b1;
                        end
                        if (i_rd && !o_empty) begin
                                rptr <= rptr + 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

/* hw/rx_frame_merge.sv */
// frame merger: round-robin frame-level grant of two readers and registered tagged output

`timescale 1ns/1ps
`default_nettype none

module rx_frame_merge
        import gmii_rx_pkg::*;
(
        input  wire logic     i_clk,
        input  wire logic     i_rst_n,
        input  wire logic     i_req0,
        input  wire logic     i_req1,
        input  wire rx_beat_s i_beat0,
        input  wire rx_beat_s i_beat1,
        output logic          o_grant0,
        output logic          o_grant1,
        output mrg_beat_s     o_out
);

        mg_state_e state;
        // channel holding the grant
        port_id_t  cur;
        // channel preferred when both request
        port_id_t  prio;
        rx_beat_s  sel;

        assign sel      = (cur == 1'b1) ? i_beat1 : i_beat0;
        assign o_grant0 = (state == MG_HOLD) && (cur == 1'b0);
        assign o_grant1 = (state == MG_HOLD) && (cur == 1'b1);

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        state <= MG_IDLE;
                        cur   <= '0;
                        prio  <= '0;
                        o_out <= '0;
                end else begin
                        o_out <= '0;
                        case (state)
                                MG_IDLE: begin
                                        if (i_req0 || i_req1) begin
                                                state <= MG_HOLD;
                                                if (i_req0 && i_req1) begin
                                                        cur <= prio;
                                                end else begin
                                                        cur <= port_id_t'(i_req1);
                                                end
                                        end
                                end
                                MG_HOLD: begin
                                        if (sel.wr) begin
                                                o_out <= '{port: cur, beat: sel};
                                        end
                                        // frame closed, hand priority to the other port
                                        if (sel.wr && (sel.tail || sel.underflow)) begin
                                                state <= MG_IDLE;
                                                prio  <= ~cur;
                                        end
                                end
                                default: state <= MG_IDLE;
                        endcase
                end
        end

endmodule

`default_nettype wire

/* include/gmii_rx_consts.svh */
// gmii receive constants: word width, timestamp width, fifo depth, start delay, minimum length

`ifndef GMII_RX_CONSTS_SVH
`define GMII_RX_CONSTS_SVH

// one byte plus the frame mark bit
`define GMII_RX_WORD_W 9

// timer and timestamp width
`define GMII_RX_TS_W 19

// words per channel fifo, power of two
`define GMII_RX_FIFO_DEPTH 64

// non-empty cycles a granted reader waits before reading the head
`define GMII_RX_START_DELAY 3

// bursts shorter than this never reach the fifo
`define GMII_RX_MIN_LEN 2

`endif

/* sim.f */
+incdir+include
hw/gmii_rx_pkg.sv
hw/gmii_rx_writer.sv
hw/rx_fifo.sv
hw/gmii_rx_reader.sv
hw/rx_frame_merge.sv
hw/gmii_rx_top.sv
tests/gmii_rx_assertions.sv
tests/tb_gmii_rx.sv

/* tests/gmii_rx_assertions.sv */
// bound output checks: quiet reset, tail mark, head-only timestamp, no underflow

`timescale 1ns/1ps
`default_nettype none

`include "gmii_rx_consts.svh"

module gmii_rx_assertions
        import gmii_rx_pkg::*;
(
        input wire logic      i_clk,
        input wire logic      i_rst_n,
        input wire mrg_beat_s i_out
);

        logic mark;

        assign mark = i_out.beat.word[`GMII_RX_WORD_W-1];

        // no output beat while reset is held
        a_rst_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_out.beat.wr)
                else $error("output write during reset");

        a_tail_mark: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                i_out.beat.tail |-> (i_out.beat.wr && mark))
                else $error("tail beat without mark bit");

        // timestamp only rides on the head word
        a_ts_head: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (i_out.beat.ts != '0) |-> (i_out.beat.wr && mark && !i_out.beat.tail))
                else $error("timestamp on a non-head word");

        a_no_uflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !i_out.beat.underflow)
                else $error("reader underflow reached the output");

endmodule

`default_nettype wire

/* tests/tb_gmii_rx.sv */
// testbench: clock, reset, random gmii traffic on both ports, frame model, checks, watchdog

`timescale 1ns/1ps
`default_nettype none

`include "gmii_rx_consts.svh"

module tb_gmii_rx
        import gmii_rx_pkg::*;
();

        localparam int          FRAMES    = 40;
        localparam int          MAX_LEN   = 48;
        // every frame on both ports gets 200 cycles
        localparam int          WD_CYCLES = 2 * FRAMES * 200;
        localparam logic [31:0] SEED      = 32'h3b7a_15ed;

        logic       clk = 1'b0;
        logic       rst_n;
        logic [7:0] rxd [2];
        logic       rx_dv [2];
        rx_ts_t     timer = '0;
        mrg_beat_s  out_beat;

        // expected frame per port, one in flight at a time
        logic [7:0] exp_byte [2][MAX_LEN];
        int         exp_len [2];
        rx_ts_t     exp_ts [2];
        int         sent [2] = '{0, 0};
        int         rcvd [2] = '{0, 0};

        // collector state
        logic       in_frame = 1'b0;
        int         cur_port = 0;
        int         idx = 0;
        int         p;
        logic       last;

        always #5 clk = ~clk;

        // free-running receive timer
        always @(negedge clk) begin
                timer <= timer + 1'b1;
        end

        gmii_rx_top gmii_rx_top_inst (
                .i_clk    (clk),
                .i_rst_n  (rst_n),
                .i_rxd0   (rxd[0]),
                .i_rx_dv0 (rx_dv[0]),
                .i_rxd1   (rxd[1]),
                .i_rx_dv1 (rx_dv[1]),
                .i_timer  (timer),
                .o_out    (out_beat)
        );

        bind gmii_rx_top gmii_rx_assertions gmii_rx_assertions_inst (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_out   (o_out)
        );

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("** FAIL **");
                $fatal(1, "simulation stopped on error");
        endtask

        task automatic check(input string name, input logic [31:0] exp_v,
                        input logic [31:0] act_v);
                if (exp_v !== act_v) begin
                        abort_run($sformatf("FAIL at %0t: %s expected %0h, got %0h",
                                $time, name, exp_v, act_v));
                end
        endtask

        // one burst of random bytes, dv dropped after the last one
        task automatic send_frame(input int port, input int len);
                logic [7:0] b;
                int         i;
                if (len >= `GMII_RX_MIN_LEN) begin
                        exp_len[port] = len;
                        // timer steps on the same edge that drives the first byte
                        exp_ts[port]  = timer + 1'b1;
                        sent[port]    = sent[port] + 1;
                end
                for (i = 0; i < len; i++) begin
                        b                 = 8'($urandom);
                        exp_byte[port][i] = b;
                        rxd[port]        <= b;
                        rx_dv[port]      <= 1'b1;
                        @(negedge clk);
                end
                rx_dv[port] <= 1'b0;
                rxd[port]   <= '0;
        endtask

        task automatic run_port(input int port);
                int len;
                int f;
                for (f = 0; f < FRAMES; f++) begin
                        repeat ($urandom_range(12, 1)) @(negedge clk);
                        // one-byte bursts now and then
                        if ($urandom_range(7, 0) == 0) begin
                                len = 1;
                        end else begin
                                len = $urandom_range(MAX_LEN, 2);
                        end
                        send_frame(port, len);
                        while (rcvd[port] != sent[port]) begin
                                @(negedge clk);
                        end
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // output collector and frame checks
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge clk) begin
                if (rst_n) begin
                        if (!out_beat.beat.wr) begin
                                check("o_out", '0, out_beat);
                        end else begin
                                check("o_out.beat.underflow", 0, 32'(out_beat.beat.underflow));
                                p = int'(out_beat.port);
                                if (!in_frame) begin
                                        if (sent[p] == rcvd[p]) begin
                                                abort_run($sformatf(
                                                        "output beat on port %0d with no frame sent",
                                                        p));
                                        end
                                        if (out_beat.beat.ts < exp_ts[p] ||
                                                        out_beat.beat.ts > timer) begin
                                                abort_run($sformatf(
                                                        "FAIL at %0t: %s %0h not in %0h..%0h",
                                                        $time, "o_out.beat.ts", out_beat.beat.ts,
                                                        exp_ts[p], timer));
                                        end
                                        in_frame = 1'b1;
                                        cur_port = p;
                                        idx      = 0;
                                end else begin
                                        // frames never interleave
                                        check("o_out.port", 32'(cur_port), 32'(p));
                                end
                                last = (idx == exp_len[p] - 1);
                                check("o_out.beat.word[7:0]", 32'(exp_byte[p][idx]),
                                        32'(out_beat.beat.word[7:0]));
                                check("o_out.beat.word[8]", 32'(idx == 0 || last),
                                        32'(out_beat.beat.word[8]));
                                check("o_out.beat.tail", 32'(last), 32'(out_beat.beat.tail));
                                if (last) begin
                                        in_frame = 1'b0;
                                        rcvd[p]  = rcvd[p] + 1;
                                end else begin
                                        idx = idx + 1;
                                end
                        end
                end
        end

        initial begin
                void'($urandom(SEED));
                rst_n    <= 1'b0;
                rxd[0]   <= '0;
                rxd[1]   <= '0;
                rx_dv[0] <= 1'b0;
                rx_dv[1] <= 1'b0;
                repeat (16) @(posedge clk);
                @(negedge clk);
                rst_n <= 1'b1;
                fork
                        run_port(0);
                        run_port(1);
                join
                repeat (10) @(negedge clk);
                if (sent[0] == rcvd[0] && sent[1] == rcvd[1] && !in_frame) begin
                        $display("** PASS **");
                        $finish;
                end else begin
                        abort_run("frames still missing at the end of the run");
                end
        end

        // watchdog
        initial begin
                repeat (WD_CYCLES + 16) @(posedge clk);
                abort_run("watchdog expired before all frames were received");
        end

endmodule

`default_nettype wire
